//--- tb.f
+incdir+common
common/uart_pkg.sv
rtl/byte_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
rtl/uart_ctrl.sv
rtl/fduart.sv
dv/fduart_tb.sv

//--- dv/fduart_tb.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module fduart_tb;
    import uart_pkg::*;

    // one stimulus row. exp is the character the receiver should deliver.
    typedef struct packed {
        logic     loop; // 1 sends through the transmitter, 0 through the bit driver.
        byte_t    data;
        logic     stop; // stop bit level the driver puts on the line.
        rx_char_t exp;  // frame_err in bit 8, data below it.
    } stim_t;

    localparam int frame_clks = `FDUART_OVERSAMPLE * 10;
    localparam int n_stim = 6;
    // single frame, table, burst writes and receive overflow frames.
    localparam int n_frames = 1 + n_stim + (`FDUART_FIFO_DEPTH + 3) + (`FDUART_FIFO_DEPTH + 2);
    localparam int max_cycles = n_frames * frame_clks * 2 + 200;
    localparam logic [15:0] reset_status = (16'd1 << `FDUART_ATX_EMPTY_BIT) |
                                           (16'd1 << `FDUART_ARX_EMPTY_BIT);
    localparam logic [15:0] data_status = 16'd1 << `FDUART_ATX_EMPTY_BIT; // a byte waits.

    stim_t stim [n_stim] = '{
        '{1'b1, 8'h55, 1'b1, 9'h055},
        '{1'b1, 8'ha3, 1'b1, 9'h0a3},
        '{1'b0, 8'h3c, 1'b1, 9'h03c},
        '{1'b0, 8'h96, 1'b0, 9'h196}, // stop bit low, so frame_err must be set.
        '{1'b1, 8'h00, 1'b1, 9'h000},
        '{1'b1, 8'hff, 1'b1, 9'h0ff}
    };

    logic         clk_async = 1'b0;
    logic         rst;
    logic [15:0]  data_in;
    logic         atx_load;
    logic         arx_read;
    logic [15:0]  arx_data;
    uart_status_t status;
    logic [15:0]  status_bits; // status as a plain vector for bit lookups.
    logic         tx_line;
    logic         rx_line;
    logic         loop_mode;   // rx_line follows tx_line while set.
    logic         drv_line;    // line level from the bit driver.
    logic [31:0]  lfsr = 32'hf7c5_dce6;
    int           cycles = 0;
    int           load_cyc;
    int           base;
    byte_t        mon_q [$];     // bytes decoded on tx_line, in order.
    int           mon_start [$]; // cycle of each start bit seen.
    byte_t        sent [$];

    always #2 clk_async = ~clk_async;

    assign rx_line     = loop_mode ? tx_line : drv_line;
    assign status_bits = status;

    fduart i_fduart (.*);

    always @(posedge clk_async) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %0h, expected %0h", name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // galois LFSR stepped once for every bit taken. bits are collected LSB first.
    function automatic byte_t lfsr_byte();
        byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return b;
    endfunction

    // decodes every frame on tx_line and checks each bit is held for a full bit time.
    always begin : frame_monitor
        logic [frame_clks-1:0] samp;
        byte_t                 d;
        @(negedge clk_async);
        if (!rst && tx_line === 1'b0) begin
            mon_start.push_back(cycles);
            for (int k = 0; k < frame_clks; k++) begin
                samp[k] = tx_line;
                if (k < frame_clks - 1) @(negedge clk_async);
            end
            for (int b = 0; b < 10; b++) begin
                for (int m = 1; m < `FDUART_OVERSAMPLE; m++) begin
                    check_equal("tx_line", samp[`FDUART_OVERSAMPLE * b + m],
                                samp[`FDUART_OVERSAMPLE * b]);
                end
            end
            check_equal("tx_line stop bit", samp[`FDUART_OVERSAMPLE * 9], 1'b1);
            for (int j = 0; j < 8; j++) d[j] = samp[`FDUART_OVERSAMPLE * (j + 1)];
            mon_q.push_back(d);
        end
    end

    task automatic write_byte(input byte_t b);
        @(posedge clk_async);
        data_in  <= {8'h00, b};
        atx_load <= 1'b1;
        @(negedge clk_async);
        load_cyc = cycles; // the cycle in which the strobe is seen.
        @(posedge clk_async);
        atx_load <= 1'b0;
    endtask

    task automatic send_frame(input byte_t b, input logic stop);
        logic [9:0] bits;
        bits = {stop, b, 1'b0};
        for (int j = 0; j < 10; j++) begin
            @(posedge clk_async);
            drv_line <= bits[j];
            repeat (`FDUART_OVERSAMPLE - 1) @(posedge clk_async);
        end
        @(posedge clk_async);
        drv_line <= 1'b1;
    endtask

    task automatic wait_status(input int pos, input logic val);
        do begin
            @(negedge clk_async);
        end while (status_bits[pos] !== val);
    endtask

    task automatic read_expect(input rx_char_t exp);
        wait_status(`FDUART_ARX_EMPTY_BIT, 1'b0);
        check_equal("arx_data", arx_data, {7'd0, exp});
        @(posedge clk_async);
        arx_read <= 1'b1;
        @(posedge clk_async);
        arx_read <= 1'b0;
        repeat (2) @(negedge clk_async); // status is registered and shows the pop one clock later.
    endtask

    initial begin
        rst       = 1'b1;
        data_in   = '0;
        atx_load  = 1'b0;
        arx_read  = 1'b0;
        loop_mode = 1'b0;
        drv_line  = 1'b1;
        repeat (10) @(posedge clk_async);
        rst <= 1'b0;
        @(negedge clk_async);
        check_equal("status", status, reset_status);
        check_equal("tx_line", tx_line, 1'b1);
        check_equal("arx_data", arx_data, 16'h0000);
        // single frame with the receiver parked on the idle driver.
        write_byte(8'hc6);
        while (mon_q.size() < 1) @(negedge clk_async);
        check_equal("monitor byte", mon_q[0], 8'hc6);
        check_equal("start bit delay", mon_start[0] - load_cyc, 2);
        wait_status(`FDUART_ATX_BUSY_BIT, 1'b0);
        foreach (stim[i]) begin
            @(posedge clk_async);
            loop_mode <= stim[i].loop; // both lines are idle here.
            if (stim[i].loop) begin
                write_byte(stim[i].data);
                wait_status(`FDUART_ATX_BUSY_BIT, 1'b1);
                check_equal("status.atx_empty", status.atx_empty, 1'b1); // popped at start.
            end else begin
                send_frame(stim[i].data, stim[i].stop);
            end
            wait_status(`FDUART_ARX_EMPTY_BIT, 1'b0);
            check_equal("status", status, data_status);
            read_expect(stim[i].exp);
        end
        // a back-to-back burst into the transmitter lets only depth plus one bytes through.
        @(posedge clk_async);
        loop_mode <= 1'b1;
        base = mon_q.size();
        for (int i = 0; i < `FDUART_FIFO_DEPTH + 3; i++) begin
            sent.push_back(lfsr_byte());
            @(posedge clk_async);
            data_in  <= {8'h00, sent[i]};
            atx_load <= 1'b1;
        end
        @(posedge clk_async);
        atx_load <= 1'b0;
        wait_status(`FDUART_ATX_FULL_BIT, 1'b1);
        for (int i = 0; i <= `FDUART_FIFO_DEPTH; i++) begin
            read_expect({1'b0, sent[i]});
            check_equal("monitor byte", mon_q[base + i], sent[i]);
        end
        check_equal("status", status, reset_status); // nothing left to send.
        check_equal("monitor frame count", mon_q.size(), base + `FDUART_FIFO_DEPTH + 1);
        // frames now arrive with no reads in between, so the receive FIFO overflows.
        @(posedge clk_async);
        loop_mode <= 1'b0;
        sent.delete();
        for (int i = 0; i < `FDUART_FIFO_DEPTH + 2; i++) begin
            sent.push_back(lfsr_byte());
            send_frame(sent[i], 1'b1);
        end
        wait_status(`FDUART_ARX_BUSY_BIT, 1'b0);
        check_equal("status.arx_full", status.arx_full, 1'b1);
        for (int i = 0; i < `FDUART_FIFO_DEPTH; i++) read_expect({1'b0, sent[i]});
        check_equal("status", status, reset_status);
        check_equal("arx_data", arx_data, 16'h0000);
        $display("sim passed");
        $finish;
    end

endmodule

//--- rtl/fduart.sv
`timescale 1ns/1ns

module fduart (
    input  logic                   clk_async,
    input  logic                   rst,
    input  logic [15:0]            data_in,
    input  logic                   atx_load,
    input  logic                   arx_read,
    output logic [15:0]            arx_data,
    output uart_pkg::uart_status_t status,
    output logic                   tx_line,
    input  logic                   rx_line
);
    import uart_pkg::*;

    byte_t    tx_head;  // next byte to send.
    logic     tx_empty;
    logic     tx_full;
    logic     tx_busy;
    logic     tx_start; // starts a frame and pops the transmit FIFO.
    rx_char_t rx_char;  // character from the deserializer.
    rx_char_t rx_head;  // oldest unread character.
    logic     rx_valid;
    logic     rx_push;
    logic     rx_empty;
    logic     rx_full;
    logic     rx_busy;

    uart_ctrl i_ctrl (
        .clk_async(clk_async),
        .rst      (rst),
        .tx_empty (tx_empty),
        .tx_full  (tx_full),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .rx_valid (rx_valid),
        .rx_full  (rx_full),
        .rx_empty (rx_empty),
        .rx_push  (rx_push),
        .rx_busy  (rx_busy),
        .rx_head  (rx_head),
        .arx_data (arx_data),
        .status   (status)
    );

    // host writes go straight in, only the low byte is sent.
    byte_fifo #(.payload_t(byte_t)) i_tx_fifo (
        .clk_async(clk_async),
        .rst      (rst),
        .push     (atx_load),
        .din      (data_in[7:0]),
        .pop      (tx_start),
        .dout     (tx_head),
        .empty    (tx_empty),
        .full     (tx_full)
    );

    uart_tx i_tx (
        .clk_async(clk_async),
        .rst      (rst),
        .start    (tx_start),
        .din      (tx_head),
        .busy     (tx_busy),
        .tx_line  (tx_line)
    );

    uart_rx i_rx (
        .clk_async(clk_async),
        .rst      (rst),
        .rx_line  (rx_line),
        .busy     (rx_busy),
        .rx_char  (rx_char),
        .rx_valid (rx_valid)
    );

    // the host read strobe acknowledges the head character.
    byte_fifo #(.payload_t(rx_char_t)) i_rx_fifo (
        .clk_async(clk_async),
        .rst      (rst),
        .push     (rx_push),
        .din      (rx_char),
        .pop      (arx_read),
        .dout     (rx_head),
        .empty    (rx_empty),
        .full     (rx_full)
    );

endmodule

//--- rtl/uart_ctrl.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_ctrl (
    input  logic                   clk_async,
    input  logic                   rst,
    input  logic                   tx_empty,
    input  logic                   tx_full,
    input  logic                   tx_busy,
    output logic                   tx_start,
    input  logic                   rx_valid,
    input  logic                   rx_full,
    input  logic                   rx_empty,
    output logic                   rx_push,
    input  logic                   rx_busy,
    input  uart_pkg::rx_char_t     rx_head,
    output logic [15:0]            arx_data,
    output uart_pkg::uart_status_t status
);
    import uart_pkg::*;

    // after reset both FIFOs are empty and nothing else is flagged.
    localparam logic [15:0] status_rst = (16'd1 << `FDUART_ATX_EMPTY_BIT) |
                                         (16'd1 << `FDUART_ARX_EMPTY_BIT);

    logic        start_q; // tx_start from the previous cycle.
    logic [15:0] flags;   // status bits before registering.

    // start a frame when a byte is waiting and the serializer is free.
    // start_q covers the cycle in which busy has not risen yet.
    assign tx_start = !tx_empty && !tx_busy && !start_q; // also pops the transmit FIFO.

    always_ff @(posedge clk_async) begin
        if (rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= tx_start;
        end
    end

    // a received character is lost when the receive FIFO has no room.
    assign rx_push = rx_valid && !rx_full;

    always_comb begin
        flags                        = '0;
        flags[`FDUART_ATX_EMPTY_BIT] = tx_empty;
        flags[`FDUART_ATX_FULL_BIT]  = tx_full;
        flags[`FDUART_ARX_EMPTY_BIT] = rx_empty;
        flags[`FDUART_ARX_FULL_BIT]  = rx_full;
        flags[`FDUART_ATX_BUSY_BIT]  = tx_busy;
        flags[`FDUART_ARX_BUSY_BIT]  = rx_busy;
    end

    always_ff @(posedge clk_async) begin
        if (rst) begin
            status <= uart_status_t'(status_rst);
        end else begin
            status <= uart_status_t'(flags); // flags lag the FIFO and engine state by one clock.
        end
    end

    // head of the receive FIFO, zero-extended, and zero when there is nothing to read.
    assign arx_data = rx_empty ? 16'd0 : {7'd0, rx_head};

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_rx (
    input  logic               clk_async,
    input  logic               rst,
    input  logic               rx_line,
    output logic               busy,
    output uart_pkg::rx_char_t rx_char,
    output logic               rx_valid
);
    // 8N1 deserializer sampling the middle of each bit.
    localparam int tick_w = (`FDUART_OVERSAMPLE > 2) ? $clog2(`FDUART_OVERSAMPLE) : 1;
    localparam logic [tick_w-1:0] last_tick = tick_w'(`FDUART_OVERSAMPLE - 1);
    localparam logic [tick_w-1:0] mid_tick  = tick_w'(`FDUART_OVERSAMPLE / 2);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } rx_state_t;

    rx_state_t         state;
    logic [1:0]        sync_q;    // two-flop synchronizer for the incoming line.
    logic              line_s;    // synchronized line.
    logic              line_prev; // line_s one clock earlier, for edge detection.
    logic [tick_w-1:0] tick_cnt;  // position inside the current bit.
    logic [2:0]        bit_cnt;   // data bit being received.
    logic              mid_bit;

    assign line_s  = sync_q[1];
    assign mid_bit = (tick_cnt == mid_tick);

    always_ff @(posedge clk_async) begin
        if (rst) begin
            sync_q    <= 2'b11; // the line idles high.
            line_prev <= 1'b1;
        end else begin
            sync_q    <= {sync_q[0], rx_line};
            line_prev <= line_s;
        end
    end

    always_ff @(posedge clk_async) begin
        if (rst) begin
            state    <= s_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0; // single-cycle strobe.
            if (state != s_idle) tick_cnt <= (tick_cnt == last_tick) ? '0 : tick_cnt + 1'b1;
            case (state)
                s_idle: begin
                    // the edge cycle counts as tick 0 of the start bit.
                    if (line_prev && !line_s) begin
                        state    <= s_start;
                        tick_cnt <= tick_w'(1);
                    end
                end
                s_start: begin
                    if (mid_bit && line_s) begin
                        state <= s_idle; // a glitch, not a real start bit.
                    end else if (tick_cnt == last_tick) begin
                        state   <= s_data;
                        bit_cnt <= '0;
                    end
                end
                s_data: begin
                    if (tick_cnt == last_tick) begin
                        if (bit_cnt == 3'd7) state <= s_stop;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                s_stop: begin
                    if (mid_bit) rx_valid <= 1'b1; // lands in the last cycle of the stop bit.
                    if (tick_cnt == last_tick) state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // received character. data enters at the top so the first bit ends in bit 0.
    always_ff @(posedge clk_async) begin
        if (state == s_data && mid_bit) rx_char.data <= {line_s, rx_char.data[7:1]};
        if (state == s_stop && mid_bit) rx_char.frame_err <= !line_s; // stop must be high.
    end

    assign busy = (state != s_idle);

endmodule

//--- uart_tx/uart_tx.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_tx (
    input  logic            clk_async,
    input  logic            rst,
    input  logic            start,
    input  uart_pkg::byte_t din,
    output logic            busy,
    output logic            tx_line
);
    // 8N1 serializer. the frame is start, eight data bits LSB first, then stop.
    localparam int frame_bits = 10;
    localparam int tick_w = (`FDUART_OVERSAMPLE > 2) ? $clog2(`FDUART_OVERSAMPLE) : 1;
    localparam logic [tick_w-1:0] last_tick = tick_w'(`FDUART_OVERSAMPLE - 1);
    localparam logic [3:0] last_bit = 4'(frame_bits - 1);

    logic [frame_bits-1:0] shreg;    // bit 0 is what the line shows right now.
    logic [tick_w-1:0]     tick_cnt; // position inside the current bit.
    logic [3:0]            bit_cnt;  // which of the ten frame bits is on the line.
    logic                  load;
    logic                  bit_end;

    assign load    = start && !busy;           // start is only honoured while idle.
    assign bit_end = busy && (tick_cnt == last_tick);

    // control side, busy rises the cycle after start and falls after the stop bit.
    always_ff @(posedge clk_async) begin
        if (rst) begin
            busy     <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (load) begin
            busy     <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (busy) begin
            tick_cnt <= (tick_cnt == last_tick) ? '0 : tick_cnt + 1'b1;
            if (bit_end) begin
                bit_cnt <= bit_cnt + 1'b1;
                // the stop bit has had its full width, so the frame is done.
                if (bit_cnt == last_bit) busy <= 1'b0;
            end
        end
    end

    // frame shift register, ones shift in from the top so the line rests high.
    always_ff @(posedge clk_async) begin
        if (load) begin
            shreg <= {1'b1, din, 1'b0}; // stop, data, start.
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[frame_bits-1:1]};
        end
    end

    // the idle line is high, and only the frame register drives it while busy.
    assign tx_line = busy ? shreg[0] : 1'b1;

endmodule

//--- rtl/byte_fifo.sv
`timescale 1ns/1ns
`include "uart_macros.svh"

module byte_fifo #(
    parameter type payload_t = uart_pkg::byte_t,
    parameter int  fifo_depth = `FDUART_FIFO_DEPTH
) (
    input  logic     clk_async,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);
    // show-ahead FIFO, the head entry is always on dout and pop acts as an acknowledge.
    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(fifo_depth - 1);

    payload_t mem [fifo_depth]; // storage, no reset needed since count guards reads.

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full; // a push into a full FIFO is lost.
    assign do_pop  = pop && !empty; // a pop on an empty FIFO does nothing.

    always_ff @(posedge clk_async) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave occupancy unchanged.
            endcase
        end
    end

    always_ff @(posedge clk_async) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    assign dout  = mem[rd_ptr]; // head of the queue, valid whenever empty is low.
    assign empty = (count == '0);
    assign full  = (count == cnt_w'(fifo_depth));

endmodule

//--- common/uart_pkg.sv
package uart_pkg;

    // one data byte as it goes over the line.
    typedef logic [7:0] byte_t;

    // a received character as stored in the receive FIFO.
    // frame_err sits in bit 8, which is where the host finds it in arx_data.
    typedef struct packed {
        logic  frame_err; // stop bit was sampled low.
        byte_t data;      // payload, first bit on the line lands in bit 0.
    } rx_char_t;

    // the 16-bit status word seen by the host.
    // field order follows the FDUART_*_BIT positions, lowest field is bit 0.
    typedef struct packed {
        logic [9:0] rsvd;      // always zero.
        logic       arx_busy;  // bit 5.
        logic       atx_busy;  // bit 4.
        logic       arx_full;  // bit 3.
        logic       arx_empty; // bit 2.
        logic       atx_full;  // bit 1.
        logic       atx_empty; // bit 0.
    } uart_status_t;

endpackage

//--- common/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// entries held by each of the transmit and receive FIFOs.
`define FDUART_FIFO_DEPTH 8

// clocks per serial bit, the core clock runs at four times the bit rate.
`define FDUART_OVERSAMPLE 4

// bit positions inside the read-only status word.
`define FDUART_ATX_EMPTY_BIT 0 // transmit FIFO holds no bytes.
`define FDUART_ATX_FULL_BIT  1 // transmit FIFO cannot take another byte.
`define FDUART_ARX_EMPTY_BIT 2 // nothing waiting for the host.
`define FDUART_ARX_FULL_BIT  3 // further received bytes are dropped.
`define FDUART_ATX_BUSY_BIT  4 // a frame is being shifted out.
`define FDUART_ARX_BUSY_BIT  5 // a frame is being shifted in.

`endif
